// ==== Bender.yml ====
package:
  name: ics_periph

sources:
  - files:
      - hdl/ics_periph_pkg.sv
      - hdl/periph_address_decoder.sv
      - hdl/periph_bus_ctrl.sv
      - hdl/dsp_multiplier.sv
      - hdl/gamepad_mock.sv
      - hdl/flash_bitbang_ctrl.sv
      - hdl/ics_periph_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/ics_periph_tb.sv

// ==== hdl/dsp_multiplier.sv ====
// ##########################################################################
// Memory-mapped signed multiplier
// Two operand registers feeding a registered signed product
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module dsp_multiplier #(
    parameter int MULT_WIDTH = 16
) (
    input  wire                               vdp_clk,
    input  wire                               write_en,
    input  wire                               operand_b_sel,
    input  wire ics_periph_pkg::host_wdata_u  wdata,
    output ics_periph_pkg::data_t             product
);
    import ics_periph_pkg::*;

    logic signed [MULT_WIDTH-1:0]   operand_a;
    logic signed [MULT_WIDTH-1:0]   operand_b;
    logic signed [2*MULT_WIDTH-1:0] full_product;

    // Address bit picks which operand a write loads
    always_ff @(posedge vdp_clk) begin
        if (write_en && !operand_b_sel) begin
            operand_a <= MULT_WIDTH'(wdata.operand.value);
        end
        if (write_en && operand_b_sel) begin
            operand_b <= MULT_WIDTH'(wdata.operand.value);
        end
    end

    assign full_product = operand_a * operand_b;

    // Product follows the operands every cycle
    always_ff @(posedge vdp_clk) begin
        product <= data_t'(full_product);
    end

endmodule

`default_nettype wire

// ==== hdl/flash_bitbang_ctrl.sv ====
// ##########################################################################
// Flash bit-bang control
// Host-written register that takes over the flash pins while active
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module flash_bitbang_ctrl (
    input  wire                               vdp_clk,
    input  wire                               vdp_reset,
    input  wire                               write_en,
    input  wire ics_periph_pkg::host_wdata_u  wdata,
    output ics_periph_pkg::flash_pins_t       pins
);
    logic       active_q;
    logic       csn_q;
    logic       clk_q;
    logic [3:0] io_oe_q;
    logic [3:0] io_out_q;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            active_q <= 1'b0;
            csn_q    <= 1'b1;
            clk_q    <= 1'b0;
            io_oe_q  <= 4'h0;
        end else if (write_en) begin
            active_q <= wdata.flash.active;
            csn_q    <= wdata.flash.csn;
            clk_q    <= wdata.flash.clk;
            io_oe_q  <= wdata.flash.io_oe;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (write_en) begin
            io_out_q <= wdata.flash.io_out;
        end
    end

    // Pins released unless the host owns them
    always_comb begin
        pins.active = active_q;
        pins.csn    = active_q ? csn_q : 1'b1;
        pins.clk    = active_q ? clk_q : 1'b0;
        pins.io_oe  = active_q ? io_oe_q : 4'h0;
        pins.io_out = active_q ? io_out_q : 4'h0;
    end

    io_released: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        write_en && !wdata.flash.active |=> !pins.active && pins.io_oe == 4'h0);

endmodule

`default_nettype wire

// ==== hdl/gamepad_mock.sv ====
// ##########################################################################
// Mock gamepad
// Latches three board buttons into a shift register and clocks them out
// one bit at a time under host control
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module gamepad_mock #(
    parameter int PAD_BITS = 16
) (
    input  wire                          vdp_clk,
    input  wire                          vdp_reset,
    input  wire                          write_en,
    input  wire ics_periph_pkg::data_t   wdata,
    input  wire                          btn_1,
    input  wire                          btn_2,
    input  wire                          btn_3,
    output wire                          pad_bit
);
    logic [1:0]          pad_ctrl;
    logic                pad_clk_q;
    logic [PAD_BITS-1:0] latch_value;
    logic [PAD_BITS-1:0] pad_shift;

    // Bit 0 latch, bit 1 clock
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_ctrl  <= 2'b00;
            pad_clk_q <= 1'b0;
        end else begin
            if (write_en) begin
                pad_ctrl <= wdata[1:0];
            end
            pad_clk_q <= pad_ctrl[1];
        end
    end

    // Left, right and B buttons in pad order
    always_comb begin
        latch_value    = '0;
        latch_value[7] = btn_1;
        latch_value[6] = btn_3;
        latch_value[0] = btn_2;
    end

    always_ff @(posedge vdp_clk) begin
        if (pad_ctrl[0]) begin
            pad_shift <= latch_value;
        end
        // Shift on rising edge of the clock bit
        if (pad_ctrl[1] && !pad_clk_q) begin
            pad_shift <= {1'b0, pad_shift[PAD_BITS-1:1]};
        end
    end

    assign pad_bit = pad_shift[0];

endmodule

`default_nettype wire

// ==== hdl/ics_periph_pkg.sv ====
// ##########################################################################
// Peripheral package
// Address map, register field views and host bus structs shared by the
// peripheral blocks
// ##########################################################################

`default_nettype none

package ics_periph_pkg;

    typedef logic [23:0] addr_t;
    typedef logic [31:0] data_t;

    // Region field is addr[23:20]
    typedef enum logic [3:0] {
        REGION_STATUS = 4'd0,
        REGION_DSP    = 4'd1,
        REGION_PAD    = 4'd2,
        REGION_FLASH  = 4'd3
    } region_e;

    // Picks operand b over operand a
    localparam int DSP_SEL_BIT = 2;

    typedef struct packed {
        logic status;
        logic dsp;
        logic pad;
        logic flash;
        logic write;
    } periph_sel_t;

    typedef struct packed {
        addr_t addr;
        logic  write;
        data_t wdata;
    } host_req_t;

    typedef struct packed {
        logic [15:0] unused_hi;
        logic        active;
        logic [4:0]  unused_mid;
        logic        csn;
        logic        clk;
        logic [3:0]  io_oe;
        logic [3:0]  io_out;
    } flash_ctrl_fields_t;

    typedef struct packed {
        logic [15:0]        unused_hi;
        logic signed [15:0] value;
    } operand_fields_t;

    // Same write word, seen by the flash block or the multiplier
    typedef union packed {
        flash_ctrl_fields_t flash;
        operand_fields_t    operand;
    } host_wdata_u;

    typedef struct packed {
        logic       active;
        logic       csn;
        logic       clk;
        logic [3:0] io_oe;
        logic [3:0] io_out;
    } flash_pins_t;

    // Red LED on out of reset
    localparam logic [1:0] STATUS_RESET = 2'b01;

endpackage

`default_nettype wire

// ==== hdl/ics_periph_top.sv ====
// ##########################################################################
// Peripheral subsystem top
// Host port, address decoder, bus controller and the four register blocks
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module ics_periph_top #(
    parameter int MULT_WIDTH = 16,
    parameter int PAD_BITS   = 16
) (
    input  wire                             vdp_clk,
    input  wire                             vdp_reset,
    input  wire                             req,
    input  wire ics_periph_pkg::host_req_t  host,
    input  wire                             btn_1,
    input  wire                             btn_2,
    input  wire                             btn_3,
    input  wire [3:0]                       flash_io_in,
    output wire                             ack,
    output wire ics_periph_pkg::data_t      rdata,
    output wire                             led_r,
    output wire                             led_b,
    output wire ics_periph_pkg::flash_pins_t flash_pins
);
    import ics_periph_pkg::*;

    logic        strobe;
    periph_sel_t sel;
    data_t       dsp_product;
    logic        pad_bit;
    host_wdata_u wdata_u;
    logic        dsp_write_en;
    logic        pad_write_en;
    logic        flash_write_en;

    assign wdata_u        = host.wdata;
    assign dsp_write_en   = sel.dsp && sel.write;
    assign pad_write_en   = sel.pad && sel.write;
    assign flash_write_en = sel.flash && sel.write;

    periph_address_decoder decoder (
        .vdp_clk(vdp_clk), .vdp_reset(vdp_reset), .strobe(strobe),
        .addr(host.addr), .write(host.write), .sel(sel)
    );

    periph_bus_ctrl bus_ctrl (
        .vdp_clk(vdp_clk), .vdp_reset(vdp_reset), .req(req), .sel(sel),
        .wdata(host.wdata), .dsp_product(dsp_product), .pad_bit(pad_bit),
        .flash_io_in(flash_io_in), .ack(ack), .strobe(strobe), .rdata(rdata),
        .led_r(led_r), .led_b(led_b)
    );

    dsp_multiplier #(.MULT_WIDTH(MULT_WIDTH)) dsp (
        .vdp_clk(vdp_clk), .write_en(dsp_write_en),
        .operand_b_sel(host.addr[DSP_SEL_BIT]), .wdata(wdata_u), .product(dsp_product)
    );

    gamepad_mock #(.PAD_BITS(PAD_BITS)) pad (
        .vdp_clk(vdp_clk), .vdp_reset(vdp_reset), .write_en(pad_write_en),
        .wdata(host.wdata), .btn_1(btn_1), .btn_2(btn_2), .btn_3(btn_3), .pad_bit(pad_bit)
    );

    flash_bitbang_ctrl flash_ctrl (
        .vdp_clk(vdp_clk), .vdp_reset(vdp_reset), .write_en(flash_write_en),
        .wdata(wdata_u), .pins(flash_pins)
    );

endmodule

`default_nettype wire

// ==== hdl/periph_address_decoder.sv ====
// ##########################################################################
// Peripheral address decoder
// Registers a one-hot region select from the host address on each strobe
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module periph_address_decoder (
    input  wire                          vdp_clk,
    input  wire                          vdp_reset,
    input  wire                          strobe,
    input  wire ics_periph_pkg::addr_t   addr,
    input  wire                          write,
    output ics_periph_pkg::periph_sel_t  sel
);
    import ics_periph_pkg::*;

    region_e region;

    assign region = region_e'(addr[23:20]);

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            sel <= '0;
        end else begin
            // Select lives for one cycle only
            sel <= '0;
            if (strobe) begin
                sel.write <= write;
                case (region)
                    REGION_STATUS: sel.status <= 1'b1;
                    REGION_DSP:    sel.dsp <= 1'b1;
                    REGION_PAD:    sel.pad <= 1'b1;
                    REGION_FLASH:  sel.flash <= 1'b1;
                    default:       ; // unmapped, nothing selected
                endcase
            end
        end
    end

    sel_onehot: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $onehot0({sel.status, sel.dsp, sel.pad, sel.flash}));

endmodule

`default_nettype wire

// ==== hdl/periph_bus_ctrl.sv ====
// ##########################################################################
// Peripheral bus controller
// Runs the four-phase req/ack handshake, holds the status LED register and
// captures read data from the selected peripheral
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module periph_bus_ctrl (
    input  wire                               vdp_clk,
    input  wire                               vdp_reset,
    input  wire                               req,
    input  wire ics_periph_pkg::periph_sel_t  sel,
    input  wire ics_periph_pkg::data_t        wdata,
    input  wire ics_periph_pkg::data_t        dsp_product,
    input  wire                               pad_bit,
    input  wire [3:0]                         flash_io_in,
    output logic                              ack,
    output logic                              strobe,
    output ics_periph_pkg::data_t             rdata,
    output wire                               led_r,
    output wire                               led_b
);
    import ics_periph_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DECODE,
        ST_RESPOND,
        ST_RELEASE
    } state_e;

    state_e     state;
    logic [1:0] status_q;
    data_t      read_word;

    assign led_r = status_q[0];
    assign led_b = status_q[1];

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state  <= ST_IDLE;
            strobe <= 1'b0;
            ack    <= 1'b0;
        end else begin
            strobe <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        strobe <= 1'b1;
                        state  <= ST_DECODE;
                    end
                end
                // Decoder registers the select here
                ST_DECODE: state <= ST_RESPOND;
                ST_RESPOND: begin
                    ack   <= 1'b1;
                    state <= ST_RELEASE;
                end
                // Hold ack until the host lets go of req
                ST_RELEASE: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status_q <= STATUS_RESET;
        end else if (sel.status && sel.write) begin
            status_q <= wdata[1:0];
        end
    end

    // Unmapped regions read as zero
    always_comb begin
        read_word = '0;
        if (sel.status) begin
            read_word = data_t'(status_q);
        end else if (sel.dsp) begin
            read_word = dsp_product;
        end else if (sel.pad) begin
            read_word = data_t'(pad_bit);
        end else if (sel.flash) begin
            read_word = data_t'(flash_io_in);
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (state == ST_RESPOND) begin
            rdata <= read_word;
        end
    end

    ack_needs_req: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(ack) |-> req);

    strobe_once: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        strobe |=> !strobe until (ack && !req));

endmodule

`default_nettype wire

// ==== ics_periph.f ====
+incdir+include
hdl/ics_periph_pkg.sv
hdl/periph_address_decoder.sv
hdl/periph_bus_ctrl.sv
hdl/dsp_multiplier.sv
hdl/gamepad_mock.sv
hdl/flash_bitbang_ctrl.sv
hdl/ics_periph_top.sv
verification/ics_periph_tb.sv

// ==== include/ics_periph_tb_host.svh ====
// ##########################################################################
// Host bus helpers for the peripheral testbench
// Four-phase req/ack transfers and an xorshift number generator
// ##########################################################################

`ifndef ICS_PERIPH_TB_HOST_SVH
`define ICS_PERIPH_TB_HOST_SVH

// One four-phase transfer, req optionally held after ack
task automatic host_transfer(input addr_t addr, input logic write, input data_t wdata,
                             input int hold);
    int waited;
    waited = 0;
    host.addr  <= addr;
    host.write <= write;
    host.wdata <= wdata;
    req        <= 1'b1;
    do begin
        @(posedge vdp_clk);
        waited++;
    end while (!ack && waited < ACK_TIMEOUT);
    if (!ack) begin
        $display("%0t host transfer to %h got no ack within %0d cycles",
                 $time, addr, ACK_TIMEOUT);
        error_count++;
    end
    repeat (hold) @(posedge vdp_clk);
    req    <= 1'b0;
    waited = 0;
    do begin
        @(posedge vdp_clk);
        waited++;
    end while (ack && waited < ACK_TIMEOUT);
    if (ack) begin
        $display("%0t ack to %h stayed high after req dropped", $time, addr);
        error_count++;
    end
endtask

task automatic host_write(input addr_t addr, input data_t wdata);
    check_read = 1'b0;
    host_transfer(addr, 1'b1, wdata, 0);
endtask

task automatic host_read(input addr_t addr, input data_t expected, input int hold = 0);
    exp_rdata  = expected;
    check_read = 1'b1;
    host_transfer(addr, 1'b0, '0, hold);
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
endfunction

function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

`endif

// ==== verification/ics_periph_tb.sv ====
// ##########################################################################
// Peripheral subsystem testbench
// Drives the host port through status, multiplier, gamepad and flash
// accesses while concurrent assertions check handshake and data
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module ics_periph_tb;
    import ics_periph_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int ACK_TIMEOUT  = 16;
    // A transfer takes 6 cycles, the rest covers held req
    localparam int TXN_CYCLES   = 10;
    localparam int LED_ROUNDS   = 8;
    localparam int MULT_PAIRS   = 20;
    localparam int PAD_PULSES   = 10;
    localparam int FLASH_ROUNDS = 4;
    localparam int TXN_TOTAL    = 1 + 4 + 2 * LED_ROUNDS + 3 * MULT_PAIRS
                                  + 2 * (3 + 3 * PAD_PULSES) + 3 * FLASH_ROUNDS;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TXN_TOTAL * TXN_CYCLES + 200;

    localparam addr_t ADDR_STATUS   = 24'h000000;
    localparam addr_t ADDR_OP_A     = 24'h100000;
    localparam addr_t ADDR_OP_B     = 24'h100000 | (24'd1 << DSP_SEL_BIT);
    localparam addr_t ADDR_PAD      = 24'h200000;
    localparam addr_t ADDR_FLASH    = 24'h300000;
    localparam addr_t ADDR_UNMAPPED = 24'h500000;

    localparam flash_pins_t PINS_RELEASED = '{active: 1'b0, csn: 1'b1, clk: 1'b0,
                                              io_oe: 4'h0, io_out: 4'h0};

    logic        vdp_clk = 1'b0;
    logic        vdp_reset;
    logic        req;
    host_req_t   host;
    logic        btn_1;
    logic        btn_2;
    logic        btn_3;
    logic [3:0]  flash_io_in;
    logic        ack;
    data_t       rdata;
    logic        led_r;
    logic        led_b;
    flash_pins_t flash_pins;

    // Expected values for the checking assertions
    logic        check_read;
    data_t       exp_rdata;
    logic [1:0]  exp_led;
    flash_pins_t exp_pins;

    logic [31:0] rng_state;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          errors_at_start;

    always #(CLK_PERIOD / 2) vdp_clk = ~vdp_clk;

    ics_periph_top #(.MULT_WIDTH(16), .PAD_BITS(16)) DUT (
        .vdp_clk(vdp_clk), .vdp_reset(vdp_reset), .req(req), .host(host),
        .btn_1(btn_1), .btn_2(btn_2), .btn_3(btn_3), .flash_io_in(flash_io_in),
        .ack(ack), .rdata(rdata), .led_r(led_r), .led_b(led_b), .flash_pins(flash_pins)
    );

    `include "ics_periph_tb_host.svh"

    // Serial pad order is btn_2, five zeros, btn_3, btn_1, then zeros
    function automatic logic pad_expected(input int step, input logic [2:0] buttons);
        case (step)
            0:       return buttons[1];
            6:       return buttons[2];
            7:       return buttons[0];
            default: return 1'b0;
        endcase
    endfunction

    task automatic report_test(input string name);
        // Give the last transfer's assertions time to settle
        repeat (2) @(posedge vdp_clk);
        tests_run++;
        if (error_count != errors_at_start) begin
            tests_failed++;
            $display("%s: %0d errors", name, error_count - errors_at_start);
        end else begin
            $display("%s: ok", name);
        end
        errors_at_start = error_count;
    endtask

    ack_latency: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(req) |-> !ack ##1 !ack ##1 !ack ##1 ack)
        else begin
            $display("%0t ack did not follow req by exactly 3 cycles", $time);
            error_count++;
        end

    ack_hold: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        ack && req |=> ack)
        else begin
            $display("%0t ack dropped while req was still high", $time);
            error_count++;
        end

    ack_release: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $fell(req) |-> ack ##1 !ack)
        else begin
            $display("%0t ack did not fall one cycle after req dropped", $time);
            error_count++;
        end

    req_after_ack: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(req) |-> !ack)
        else begin
            $display("%0t req rose while ack was still high", $time);
            error_count++;
        end

    rdata_value: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(ack) && check_read |-> rdata == exp_rdata)
        else begin
            $display("[ERROR] %0t rdata expected %h got %h", $time, exp_rdata, $sampled(rdata));
            error_count++;
        end

    led_r_value: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(ack) |-> led_r == exp_led[0])
        else begin
            $display("[ERROR] %0t led_r expected %b got %b", $time, exp_led[0], $sampled(led_r));
            error_count++;
        end

    led_b_value: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(ack) |-> led_b == exp_led[1])
        else begin
            $display("[ERROR] %0t led_b expected %b got %b", $time, exp_led[1], $sampled(led_b));
            error_count++;
        end

    pins_value: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(ack) |-> flash_pins == exp_pins)
        else begin
            $display("[ERROR] %0t flash_pins expected %h got %h",
                     $time, exp_pins, $sampled(flash_pins));
            error_count++;
        end

    reset_ack: assert property (@(posedge vdp_clk) $fell(vdp_reset) |-> !ack)
        else begin
            $display("[ERROR] %0t ack expected 0 got %b", $time, $sampled(ack));
            error_count++;
        end

    reset_pins: assert property (@(posedge vdp_clk)
        $fell(vdp_reset) |-> flash_pins == PINS_RELEASED)
        else begin
            $display("[ERROR] %0t flash_pins expected %h got %h",
                     $time, PINS_RELEASED, $sampled(flash_pins));
            error_count++;
        end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0]        r;
        logic [1:0]         led_value;
        logic signed [15:0] op_a;
        logic signed [15:0] op_b;
        logic signed [31:0] expected_product;
        logic [2:0]         buttons;

        vdp_reset       <= 1'b1;
        req             <= 1'b0;
        host            <= '0;
        btn_1           <= 1'b0;
        btn_2           <= 1'b0;
        btn_3           <= 1'b0;
        flash_io_in     <= 4'h0;
        check_read      = 1'b0;
        exp_rdata       = '0;
        exp_led         = 2'b01;
        exp_pins        = PINS_RELEASED;
        rng_state       = 32'h1f1d9959;
        error_count     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        errors_at_start = 0;
        repeat (RESET_CYCLES) @(posedge vdp_clk);
        vdp_reset <= 1'b0;
        repeat (2) @(posedge vdp_clk);

        host_read(ADDR_STATUS, 32'd1);
        report_test("reset_state");

        // Unmapped accesses and a host that keeps req up after ack
        host_write(ADDR_UNMAPPED, next_random());
        host_read(ADDR_UNMAPPED, 32'd0);
        host_read(24'hf00010, 32'd0, 5);
        host_read(ADDR_STATUS, 32'd1, 3);
        report_test("handshake");

        for (int i = 0; i < LED_ROUNDS; i++) begin
            r         = next_random();
            led_value = r[1:0];
            exp_led   = led_value;
            host_write(ADDR_STATUS, r);
            host_read(ADDR_STATUS, {30'd0, led_value});
        end
        report_test("status_leds");

        for (int i = 0; i < MULT_PAIRS; i++) begin
            r    = next_random();
            op_a = r[15:0];
            host_write(ADDR_OP_A, r);
            r    = next_random();
            op_b = r[15:0];
            host_write(ADDR_OP_B, r);
            // Signed operands widen to the 32-bit result
            expected_product = op_a * op_b;
            host_read(ADDR_OP_A, expected_product);
        end
        report_test("multiplier");

        for (int round = 0; round < 2; round++) begin
            // Each button gets its own pattern over the two rounds
            buttons = (round == 0) ? 3'b101 : 3'b110;
            btn_1   <= buttons[0];
            btn_2   <= buttons[1];
            btn_3   <= buttons[2];
            host_write(ADDR_PAD, 32'h1);
            host_write(ADDR_PAD, 32'h0);
            host_read(ADDR_PAD, {31'd0, pad_expected(0, buttons)});
            for (int step = 1; step <= PAD_PULSES; step++) begin
                host_write(ADDR_PAD, 32'h2);
                host_write(ADDR_PAD, 32'h0);
                host_read(ADDR_PAD, {31'd0, pad_expected(step, buttons)});
            end
        end
        report_test("gamepad");

        for (int i = 0; i < FLASH_ROUNDS; i++) begin
            r           = next_random();
            flash_io_in <= r[19:16];
            exp_pins    = '{active: 1'b1, csn: r[9], clk: r[8], io_oe: r[7:4], io_out: r[3:0]};
            host_write(ADDR_FLASH, {r[31:16], 1'b1, r[14:0]});
            host_read(ADDR_FLASH, {28'd0, r[19:16]});
            // Active clear releases the pins whatever else is set
            exp_pins = PINS_RELEASED;
            host_write(ADDR_FLASH, {r[31:16], 1'b0, r[14:10], 1'b0, 1'b1, 8'hff});
        end
        report_test("flash_bitbang");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
